// ==== Makefile ====
# Verilator build and run for the rv64 execute unit testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_exec
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard rtl/*.sv) $(wildcard tb/*.sv) $(wildcard include/*.svh)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
+incdir+include
rtl/rv_exec_pkg.sv
rtl/rv_wb_regs.sv
rtl/rv_decode.sv
rtl/rv_alu.sv
rtl/rv_result.sv
rtl/rv_exec_top.sv
tb/tb_rv_exec.sv

// ==== rtl/rv_alu.sv ====
// combinational 64-bit alu, op must be one-hot or zero (zero gives y = 0)
`timescale 1ns/1ps

module rv_alu import rv_exec_pkg::*; (
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	input  alu_op_t         op,
	output logic [xlen-1:0] y
);

	logic            inv;
	logic [xlen-1:0] adder_b;
	logic [xlen-1:0] sum;
	logic            cout;
	logic [xlen-1:0] slt_res;
	logic [xlen-1:0] sltu_res;
	logic [xlen-1:0] sll_res;
	logic [xlen-1:0] srl_res;
	logic [xlen-1:0] sra_res;
	logic [xlen-1:0] lui_res;

	// one adder for add, sub and both compares
	assign inv           = op.do_sub | op.do_slt | op.do_sltu;
	assign adder_b       = inv ? ~b : b;
	assign {cout, sum}   = {1'b0, a} + {1'b0, adder_b} + {{xlen{1'b0}}, inv};

	// signs differ decides directly, else the sign of a - b
	assign slt_res  = {{(xlen-1){1'b0}},
		(a[xlen-1] & ~b[xlen-1]) | (~(a[xlen-1] ^ b[xlen-1]) & sum[xlen-1])};
	assign sltu_res = {{(xlen-1){1'b0}}, ~cout};  // borrow

	assign sll_res = a << b[5:0];
	assign srl_res = a >> b[5:0];
	assign sra_res = $signed(a) >>> b[5:0];

	assign lui_res = {{(xlen-32){b[19]}}, b[19:0], 12'b0};

	assign y = ({xlen{op.do_add | op.do_sub}} & sum)
		| ({xlen{op.do_slt}}  & slt_res)
		| ({xlen{op.do_sltu}} & sltu_res)
		| ({xlen{op.do_and}}  & (a & b))
		| ({xlen{op.do_or}}   & (a | b))
		| ({xlen{op.do_xor}}  & (a ^ b))
		| ({xlen{op.do_sll}}  & sll_res)
		| ({xlen{op.do_srl}}  & srl_res)
		| ({xlen{op.do_sra}}  & sra_res)
		| ({xlen{op.do_lui}}  & lui_res);

endmodule

// ==== rtl/rv_decode.sv ====
// registered rv64 decoder, one dec_t per issue pulse; anything outside OP/OP-IMM/OP-32/OP-IMM-32/LUI is illegal
`timescale 1ns/1ps

module rv_decode import rv_exec_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            issue,
	input  instr_u          instr,
	input  logic [xlen-1:0] src1,
	input  logic [xlen-1:0] src2,
	output dec_t            dec
);

	logic [2:0]      f3;
	logic [6:0]      f7;
	logic [6:0]      opcode;
	logic [xlen-1:0] imm_i;
	logic [19:0]     imm_u;
	logic            alt;  // sub or sra select
	logic            illegal_n;
	logic            word_n;
	alu_op_t         op_n;
	logic [xlen-1:0] a_n;
	logic [xlen-1:0] b_n;

	function automatic alu_op_t fn_op(input logic [2:0] f, input logic sel);
		alu_op_t o;
		o = '0;
		case (f)
			f3_add:  if (sel) o.do_sub = 1'b1; else o.do_add = 1'b1;
			f3_sll:  o.do_sll = 1'b1;
			f3_slt:  o.do_slt = 1'b1;
			f3_sltu: o.do_sltu = 1'b1;
			f3_xor:  o.do_xor = 1'b1;
			f3_sr:   if (sel) o.do_sra = 1'b1; else o.do_srl = 1'b1;
			f3_or:   o.do_or = 1'b1;
			f3_and:  o.do_and = 1'b1;
			default: o = '0;
		endcase
		return o;
	endfunction

	assign f3     = instr.r.funct3;
	assign f7     = instr.r.funct7;  // also imm12[11:5] of the i view
	assign opcode = instr.r.opcode;
	assign imm_i  = {{(xlen-12){instr.i.imm12[11]}}, instr.i.imm12};
	assign imm_u  = {instr.i.imm12, instr.i.rs1, instr.i.funct3};

	always_comb begin
		illegal_n = 1'b0;
		word_n    = 1'b0;
		alt       = 1'b0;
		a_n       = src1;
		b_n       = src2;
		case (opcode)
			op_op: begin
				alt       = f7[5];
				illegal_n = !(f7 == f7_base || (f7 == f7_alt && (f3 == f3_add || f3 == f3_sr)));
			end
			op_imm: begin
				b_n = imm_i;
				alt = (f3 == f3_sr) & f7[5];
				if (f3 == f3_sll)
					illegal_n = f7[6:1] != 6'd0;
				else if (f3 == f3_sr)
					illegal_n = f7[6:1] != 6'd0 && f7[6:1] != f7_alt[6:1];
			end
			op_32, op_imm_32: begin
				word_n = 1'b1;
				if (opcode == op_imm_32)
					b_n = imm_i;
				alt = f7[5] & (f3 == f3_sr || (opcode == op_32 && f3 == f3_add));
				if (f3 != f3_add && f3 != f3_sll && f3 != f3_sr)
					illegal_n = 1'b1;
				else if (opcode == op_32 || f3 != f3_add)
					illegal_n = !(f7 == f7_base || (f7 == f7_alt && f3 != f3_sll));
				if (f3 == f3_sll || f3 == f3_sr)
					b_n = {{(xlen-5){1'b0}}, b_n[4:0]};  // 5-bit shamt
				if (f3 == f3_sr)  // srlw sees zeros above bit 31, sraw the sign
					a_n = {{(xlen-32){alt & src1[31]}}, src1[31:0]};
			end
			op_lui: begin
				a_n = '0;
				b_n = {{(xlen-20){1'b0}}, imm_u};
			end
			default: illegal_n = 1'b1;
		endcase

		if (illegal_n)
			op_n = '0;
		else if (opcode == op_lui) begin
			op_n = '0;
			op_n.do_lui = 1'b1;
		end else
			op_n = fn_op(f3, alt);
	end

	always_ff @(posedge clk) begin
		if (rst)
			dec.valid <= 1'b0;
		else
			dec.valid <= issue;
		if (issue) begin
			dec.illegal <= illegal_n;
			dec.word    <= word_n;
			dec.op      <= op_n;
			dec.a       <= a_n;
			dec.b       <= b_n;
		end
	end

	a_op_onehot: assert property (@(posedge clk) disable iff (rst)
		dec.valid && !dec.illegal |-> $onehot(dec.op));

endmodule

// ==== rtl/rv_exec_pkg.sv ====
// rv64 execute unit shared types; widths fixed by rv64, register map is word addressed on a 3-bit adr
package rv_exec_pkg;

	localparam int xlen = 64;

	// wishbone register map
	localparam logic [2:0] adr_src1   = 3'd0;
	localparam logic [2:0] adr_src2   = 3'd1;
	localparam logic [2:0] adr_instr  = 3'd2;
	localparam logic [2:0] adr_result = 3'd3;
	localparam logic [2:0] adr_status = 3'd4;

	// major opcodes handled here, everything else is illegal
	localparam logic [6:0] op_op     = 7'b0110011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_32     = 7'b0111011;
	localparam logic [6:0] op_imm_32 = 7'b0011011;
	localparam logic [6:0] op_lui    = 7'b0110111;

	localparam logic [2:0] f3_add  = 3'd0;  // add, sub
	localparam logic [2:0] f3_sll  = 3'd1;
	localparam logic [2:0] f3_slt  = 3'd2;
	localparam logic [2:0] f3_sltu = 3'd3;
	localparam logic [2:0] f3_xor  = 3'd4;
	localparam logic [2:0] f3_sr   = 3'd5;  // srl, sra
	localparam logic [2:0] f3_or   = 3'd6;
	localparam logic [2:0] f3_and  = 3'd7;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000;  // sub and sra

	// one-hot, do_add is bit 0 and do_lui bit 10
	typedef struct packed {
		logic do_lui;
		logic do_sra;
		logic do_srl;
		logic do_sll;
		logic do_xor;
		logic do_or;
		logic do_and;
		logic do_sltu;
		logic do_slt;
		logic do_sub;
		logic do_add;
	} alu_op_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_r_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} instr_i_t;

	// lui immediate is {imm12, rs1, funct3} of the i view
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	typedef struct packed {
		logic            cyc;
		logic            stb;
		logic            we;
		logic [2:0]      adr;
		logic [xlen-1:0] dat_w;
	} wb_req_t;

	typedef struct packed {
		logic            ack;
		logic [xlen-1:0] dat_r;
	} wb_rsp_t;

	typedef struct packed {
		logic            valid;
		logic            illegal;
		logic            word;  // W variant, result sign extended from bit 31
		alu_op_t         op;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
	} dec_t;

endpackage

// ==== rtl/rv_exec_top.sv ====
// rv64 execute unit top, result readable two clocks after the instruction write is acked
`timescale 1ns/1ps

module rv_exec_top import rv_exec_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  wb_req_t wb_i,
	output wb_rsp_t wb_o
);

	logic            issue;
	logic            pending;
	logic            illegal;
	instr_u          instr;
	logic [xlen-1:0] src1;
	logic [xlen-1:0] src2;
	logic [xlen-1:0] y;
	logic [xlen-1:0] result;
	dec_t            dec;

	rv_wb_regs i_regs (
		.clk     (clk),
		.rst     (rst),
		.wb_i    (wb_i),
		.wb_o    (wb_o),
		.issue   (issue),
		.instr   (instr),
		.src1    (src1),
		.src2    (src2),
		.pending (pending),
		.result  (result),
		.illegal (illegal)
	);

	rv_decode i_decode (
		.clk   (clk),
		.rst   (rst),
		.issue (issue),
		.instr (instr),
		.src1  (src1),
		.src2  (src2),
		.dec   (dec)
	);

	rv_alu i_alu (
		.a  (dec.a),
		.b  (dec.b),
		.op (dec.op),
		.y  (y)
	);

	rv_result i_result (
		.clk     (clk),
		.rst     (rst),
		.issue   (issue),
		.dec     (dec),
		.y       (y),
		.result  (result),
		.illegal (illegal),
		.pending (pending)
	);

endmodule

// ==== rtl/rv_result.sv ====
// result stage, keeps the last registered result only; at most two operations in flight
`timescale 1ns/1ps

module rv_result import rv_exec_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            issue,
	input  dec_t            dec,
	input  logic [xlen-1:0] y,
	output logic [xlen-1:0] result,
	output logic            illegal,
	output logic            pending
);

	logic [1:0] cnt;  // issued but not yet registered

	always_ff @(posedge clk) begin
		if (rst) begin
			result  <= '0;
			illegal <= 1'b0;
			cnt     <= 2'd0;
		end else begin
			if (dec.valid) begin
				illegal <= dec.illegal;
				if (dec.illegal)
					result <= '0;
				else if (dec.word)
					result <= {{(xlen-32){y[31]}}, y[31:0]};
				else
					result <= y;
			end
			case ({issue, dec.valid})
				2'b10:   cnt <= cnt + 2'd1;
				2'b01:   cnt <= cnt - 2'd1;
				default: cnt <= cnt;  // none, or one in and one out
			endcase
		end
	end

	// issue counts at once so a racing read still stalls
	assign pending = (cnt != 2'd0) | issue;

	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		dec.valid && !issue |-> cnt != 2'd0);

endmodule

// ==== rtl/rv_wb_regs.sv ====
// wishbone classic slave, full 64-bit words only, no sel/err/rty, stb must drop before the next access
`timescale 1ns/1ps

module rv_wb_regs import rv_exec_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  wb_req_t         wb_i,
	output wb_rsp_t         wb_o,
	output logic            issue,
	output instr_u          instr,
	output logic [xlen-1:0] src1,
	output logic [xlen-1:0] src2,
	input  logic            pending,
	input  logic [xlen-1:0] result,
	input  logic            illegal
);

	logic            req;
	logic            held;  // acked, waiting for stb low
	logic            stall;
	logic            take;
	logic            ack_q;
	logic [xlen-1:0] dat_q;
	logic [xlen-1:0] rd_data;

	assign req   = wb_i.cyc & wb_i.stb;
	assign stall = ~wb_i.we & (wb_i.adr == adr_result) & pending;  // result read waits
	assign take  = req & ~ack_q & ~held & ~stall;

	assign wb_o.ack   = ack_q;
	assign wb_o.dat_r = dat_q;

	always_comb begin
		case (wb_i.adr)
			adr_src1:   rd_data = src1;
			adr_src2:   rd_data = src2;
			adr_instr:  rd_data = {{(xlen-32){1'b0}}, instr};
			adr_result: rd_data = result;
			adr_status: rd_data = {{(xlen-2){1'b0}}, illegal, ~pending};
			default:    rd_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			held  <= 1'b0;
			issue <= 1'b0;
		end else begin
			ack_q <= take;
			issue <= take & wb_i.we & (wb_i.adr == adr_instr);
			if (!req)
				held <= 1'b0;
			else if (ack_q)
				held <= 1'b1;  // stb still up after ack
		end
	end

	// operand and read data registers
	always_ff @(posedge clk) begin
		if (take && wb_i.we) begin
			case (wb_i.adr)
				adr_src1:  src1 <= wb_i.dat_w;
				adr_src2:  src2 <= wb_i.dat_w;
				adr_instr: instr <= wb_i.dat_w[31:0];
				default:   ;
			endcase
		end
		if (take && !wb_i.we)
			dat_q <= rd_data;
	end

	a_ack_single: assert property (@(posedge clk) disable iff (rst)
		ack_q |=> !ack_q);

	// issue comes with the ack of a write to the instruction register
	a_issue_src: assert property (@(posedge clk) disable iff (rst)
		issue |-> ack_q && $past(wb_i.we && wb_i.adr == adr_instr));

endmodule

// ==== include/tb_rv_model.svh ====
// reference model and bus tasks; the including scope imports rv_exec_pkg and owns clk, wb_i and wb_o
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// expected result and illegal flag for one instruction
function automatic void rv_ref(input instr_u ins, input logic [xlen-1:0] s1,
		input logic [xlen-1:0] s2, output logic [xlen-1:0] res, output logic ill);
	logic [xlen-1:0] b;
	logic [31:0]     w;
	logic            reg_form;
	logic            alt;
	logic            alt_ok;
	reg_form = ins.r.opcode == op_op || ins.r.opcode == op_32;
	b        = reg_form ? s2 : {{(xlen-12){ins.i.imm12[11]}}, ins.i.imm12};
	alt      = ins.r.funct7[5] && (reg_form || ins.r.funct3 == f3_sr);
	alt_ok   = ins.r.funct3 == f3_add || ins.r.funct3 == f3_sr;  // only sub and sra have alt
	ill      = 1'b0;
	if (reg_form)
		ill = ins.r.funct7 != f7_base && !(ins.r.funct7 == f7_alt && alt_ok);
	else if (ins.r.opcode == op_imm && ins.r.funct3 == f3_sll)
		ill = ins.i.imm12[11:6] != 6'd0;
	else if (ins.r.opcode == op_imm && ins.r.funct3 == f3_sr)
		ill = ins.i.imm12[11:6] != 6'd0 && ins.i.imm12[11:6] != f7_alt[6:1];
	else if (ins.r.opcode == op_imm_32 && ins.r.funct3 == f3_sll)
		ill = ins.r.funct7 != f7_base;
	else if (ins.r.opcode == op_imm_32 && ins.r.funct3 == f3_sr)
		ill = ins.r.funct7 != f7_base && ins.r.funct7 != f7_alt;
	res      = '0;
	w        = '0;
	case (ins.r.opcode)
		op_op, op_imm: begin
			case (ins.r.funct3)
				f3_add:  res = alt ? s1 - b : s1 + b;
				f3_sll:  res = s1 << b[5:0];
				f3_slt:  res = {{(xlen-1){1'b0}}, $signed(s1) < $signed(b)};
				f3_sltu: res = {{(xlen-1){1'b0}}, s1 < b};
				f3_xor:  res = s1 ^ b;
				f3_or:   res = s1 | b;
				f3_and:  res = s1 & b;
				default: if (alt) res = $signed(s1) >>> b[5:0]; else res = s1 >> b[5:0];
			endcase
		end
		op_32, op_imm_32: begin
			case (ins.r.funct3)
				f3_add:  w = alt ? s1[31:0] - b[31:0] : s1[31:0] + b[31:0];
				f3_sll:  w = s1[31:0] << b[4:0];
				f3_sr:   if (alt) w = $signed(s1[31:0]) >>> b[4:0]; else w = s1[31:0] >> b[4:0];
				default: ill = 1'b1;
			endcase
			res = {{(xlen-32){w[31]}}, w};
		end
		op_lui:  res = {{(xlen-32){ins.i.imm12[11]}}, ins.i.imm12, ins.i.rs1, ins.i.funct3, 12'b0};
		default: ill = 1'b1;
	endcase
	if (ill)
		res = '0;
endfunction

task automatic wb_write(input logic [2:0] adr, input logic [xlen-1:0] dat);
	@(negedge clk);
	wb_i.cyc   = 1'b1;
	wb_i.stb   = 1'b1;
	wb_i.we    = 1'b1;
	wb_i.adr   = adr;
	wb_i.dat_w = dat;
	do @(negedge clk); while (!wb_o.ack);
	wb_i.cyc = 1'b0;
	wb_i.stb = 1'b0;
	wb_i.we  = 1'b0;
endtask

task automatic wb_read(input logic [2:0] adr, output logic [xlen-1:0] dat);
	@(negedge clk);
	wb_i.cyc = 1'b1;
	wb_i.stb = 1'b1;
	wb_i.we  = 1'b0;
	wb_i.adr = adr;
	do @(negedge clk); while (!wb_o.ack);  // result reads may stall here
	dat      = wb_o.dat_r;
	wb_i.cyc = 1'b0;
	wb_i.stb = 1'b0;
endtask

`endif

// ==== tb/tb_rv_exec.sv ====
// testbench for rv_exec_top; include/ must be on the include path, fixed seed, about 825 tests
`timescale 1ns/1ps

module tb_rv_exec import rv_exec_pkg::*; ();

	localparam int n_random = 500;
	localparam int n_tests  = 160 + 144 + 4 + 14 + 2 + 1 + n_random;
	localparam int wd_ns    = (n_tests * 20 + 10) * 100;  // 20 cycles per test plus reset

	logic    clk;
	logic    rst;
	wb_req_t wb_i;
	wb_rsp_t wb_o;
	integer  seed;
	int      n_run;
	int      n_fail;
	event    result_ev;

	string           name_q[$];
	logic [xlen-1:0] exp_res_q[$];
	logic [xlen-1:0] act_res_q[$];
	logic [xlen-1:0] exp_st_q[$];
	logic [xlen-1:0] act_st_q[$];

	// OP function table, imm forms reuse it
	string      fn_name [10] = '{"add", "sub", "sll", "slt", "sltu", "xor", "srl", "sra", "or", "and"};
	logic [2:0] f3_list [10] = '{f3_add, f3_add, f3_sll, f3_slt, f3_sltu, f3_xor, f3_sr, f3_sr,
		f3_or, f3_and};
	logic [6:0] f7_list [10] = '{f7_base, f7_alt, f7_base, f7_base, f7_base, f7_base, f7_base,
		f7_alt, f7_base, f7_base};
	logic [xlen-1:0] corner [4] = '{64'd0, {xlen{1'b1}}, 64'h8000_0000_0000_0000, 64'd63};
	logic [11:0]     imm_list [4] = '{12'h000, 12'hfff, 12'h800, 12'h7ff};
	logic [5:0]      shamt_list [4] = '{6'd0, 6'd1, 6'd31, 6'd63};

	`include "tb_rv_model.svh"

	rv_exec_top i_dut (
		.clk  (clk),
		.rst  (rst),
		.wb_i (wb_i),
		.wb_o (wb_o)
	);

	always #50 clk = ~clk;

	function automatic instr_u enc_r(input logic [6:0] f7, input logic [2:0] f3,
			input logic [6:0] opc);
		return {f7, 5'd3, 5'd2, f3, 5'd1, opc};
	endfunction

	function automatic instr_u enc_i(input logic [11:0] imm, input logic [2:0] f3,
			input logic [6:0] opc);
		return {imm, 5'd2, f3, 5'd1, opc};
	endfunction

	function automatic instr_u enc_u(input logic [19:0] imm);
		return {imm, 5'd1, op_lui};
	endfunction

	// legal instructions only
	function automatic instr_u rand_instr();
		logic [31:0] r;
		logic [2:0]  kind;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		r    = $random(seed);
		kind = 3'(r[31:16] % 16'd5);
		f3   = r[2:0];
		f7   = r[3] ? f7_alt : f7_base;
		imm  = r[15:4];
		if (kind == 3'd2 || kind == 3'd3)  // word ops: add, sll or sr only
			f3 = (r[5:4] == 2'd2) ? f3_sll : ((r[5:4] == 2'd3) ? f3_sr : f3_add);
		case (kind)
			3'd0: begin
				if (f3 != f3_add && f3 != f3_sr)
					f7 = f7_base;
				return enc_r(f7, f3, op_op);
			end
			3'd1: begin
				if (f3 == f3_sll)
					imm[11:6] = 6'd0;
				else if (f3 == f3_sr)
					imm[11:6] = r[3] ? f7_alt[6:1] : 6'd0;
				return enc_i(imm, f3, op_imm);
			end
			3'd2: begin
				if (f3 == f3_sll)
					f7 = f7_base;
				return enc_r(f7, f3, op_32);
			end
			3'd3: begin
				if (f3 != f3_add)
					imm[11:5] = (f3 == f3_sr && r[3]) ? f7_alt : f7_base;
				return enc_i(imm, f3, op_imm_32);
			end
			default: return enc_u(r[19:0]);
		endcase
	endfunction

	task automatic check_result(input string name, input logic [xlen-1:0] exp,
			input logic [xlen-1:0] act, inout bit ok);
		if (act !== exp) begin
			$display("[FAIL] %s: result expected %h actual %h", name, exp, act);
			ok = 1'b0;
		end
	endtask

	// bit 0 done, bit 1 illegal
	task automatic check_status(input string name, input logic [xlen-1:0] exp,
			input logic [xlen-1:0] act, inout bit ok);
		if (act !== exp) begin
			$display("[FAIL] %s: status expected %h actual %h", name, exp, act);
			ok = 1'b0;
		end
	endtask

	task automatic post(input string name, input logic [xlen-1:0] exp_res,
			input logic [xlen-1:0] act_res, input logic [xlen-1:0] exp_st,
			input logic [xlen-1:0] act_st);
		name_q.push_back(name);
		exp_res_q.push_back(exp_res);
		act_res_q.push_back(act_res);
		exp_st_q.push_back(exp_st);
		act_st_q.push_back(act_st);
		-> result_ev;
	endtask

	task automatic run_test(input string name, input instr_u ins, input logic [xlen-1:0] s1,
			input logic [xlen-1:0] s2, output logic [xlen-1:0] act);
		logic [xlen-1:0] st;
		logic [xlen-1:0] exp;
		logic            ill;
		wb_write(adr_src1, s1);
		wb_write(adr_src2, s2);
		wb_write(adr_instr, {32'b0, ins});
		wb_read(adr_result, act);  // stalls until done
		wb_read(adr_status, st);
		rv_ref(ins, s1, s2, exp, ill);
		post(name, exp, act, {{(xlen-2){1'b0}}, ill, 1'b1}, st);
	endtask

	initial begin : compare
		string           nm;
		logic [xlen-1:0] er;
		logic [xlen-1:0] ar;
		logic [xlen-1:0] es;
		logic [xlen-1:0] acs;
		bit              ok;
		forever begin
			@(result_ev);
			while (name_q.size() != 0) begin
				nm  = name_q.pop_front();
				er  = exp_res_q.pop_front();
				ar  = act_res_q.pop_front();
				es  = exp_st_q.pop_front();
				acs = act_st_q.pop_front();
				ok  = 1'b1;
				check_result(nm, er, ar, ok);
				check_status(nm, es, acs, ok);
				n_run++;
				if (ok)
					$display("[PASS] %s", nm);
				else
					n_fail++;
			end
		end
	end

	initial begin : watchdog
		#(wd_ns);
		$display("timeout: the DUT did not finish %0d tests within %0d ns", n_tests, wd_ns);
		$display("test failed");
		$finish;
	end

	initial begin : stimulus
		int              i;
		int              j;
		int              k;
		logic [xlen-1:0] act;
		logic [xlen-1:0] act_srl;
		logic [xlen-1:0] act_sra;
		logic [xlen-1:0] st;
		logic [xlen-1:0] exp;
		logic [xlen-1:0] s1;
		logic [xlen-1:0] s2;
		logic            ill;
		instr_u          ins;
		clk    = 1'b0;
		rst    = 1'b1;
		wb_i   = '0;
		seed   = 32'hf09c_2a6a;
		n_run  = 0;
		n_fail = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// register forms on every corner pair
		for (k = 0; k < 10; k++) begin
			for (i = 0; i < 4; i++) begin
				for (j = 0; j < 4; j++) begin
					run_test($sformatf("op %s corner %0d/%0d", fn_name[k], i, j),
						enc_r(f7_list[k], f3_list[k], op_op), corner[i], corner[j], act);
				end
			end
		end

		// immediate forms, no subi
		for (k = 0; k < 10; k++) begin
			for (i = 0; i < 4; i++) begin
				for (j = 0; j < 4; j++) begin
					if (f3_list[k] == f3_sll || f3_list[k] == f3_sr)
						run_test($sformatf("opi %si corner %0d shamt %0d", fn_name[k], i,
							shamt_list[j]), enc_i({f7_list[k][6:1], shamt_list[j]},
							f3_list[k], op_imm), corner[i], corner[0], act);
					else if (f7_list[k] == f7_base)
						run_test($sformatf("opi %si corner %0d imm %h", fn_name[k], i,
							imm_list[j]), enc_i(imm_list[j], f3_list[k], op_imm),
							corner[i], corner[0], act);
				end
			end
		end

		// signs differ, slt and sltu disagree
		run_test("slt -1 < 1", enc_r(f7_base, f3_slt, op_op), {xlen{1'b1}}, 64'd1, act);
		run_test("sltu -1 < 1", enc_r(f7_base, f3_sltu, op_op), {xlen{1'b1}}, 64'd1, act);
		run_test("slt 1 < -1", enc_r(f7_base, f3_slt, op_op), 64'd1, {xlen{1'b1}}, act);
		run_test("sltu 1 < -1", enc_r(f7_base, f3_sltu, op_op), 64'd1, {xlen{1'b1}}, act);

		run_test("lui 80000", enc_u(20'h80000), 64'd5, 64'd6, act);
		run_test("lui 7ffff", enc_u(20'h7ffff), 64'd5, 64'd6, act);
		run_test("lui 12345", enc_u(20'h12345), 64'd5, 64'd6, act);
		run_test("lui fffff", enc_u(20'hfffff), 64'd5, 64'd6, act);

		// word ops on a negative low word
		s1 = 64'h1234_5678_8000_00f0;
		s2 = 64'd4;
		run_test("addw", enc_r(f7_base, f3_add, op_32), s1, s2, act);
		run_test("subw", enc_r(f7_alt, f3_add, op_32), s1, s2, act);
		run_test("sllw", enc_r(f7_base, f3_sll, op_32), s1, s2, act);
		run_test("srlw", enc_r(f7_base, f3_sr, op_32), s1, s2, act_srl);
		run_test("sraw", enc_r(f7_alt, f3_sr, op_32), s1, s2, act_sra);
		if (act_srl === act_sra) begin
			$display("srlw and sraw gave the same result on a negative word");
			n_fail++;
		end
		run_test("addiw", enc_i(12'h7ff, f3_add, op_imm_32), s1, s2, act);
		run_test("slliw", enc_i({f7_base, 5'd4}, f3_sll, op_imm_32), s1, s2, act);
		run_test("srliw", enc_i({f7_base, 5'd4}, f3_sr, op_imm_32), s1, s2, act_srl);
		run_test("sraiw", enc_i({f7_alt, 5'd4}, f3_sr, op_imm_32), s1, s2, act_sra);
		if (act_srl === act_sra) begin
			$display("srliw and sraiw gave the same result on a negative word");
			n_fail++;
		end
		run_test("addw overflow", enc_r(f7_base, f3_add, op_32), 64'h7fff_ffff, 64'd1, act);

		run_test("illegal mul", enc_r(7'b0000001, f3_add, op_op), 64'd7, 64'd9, act);
		run_test("illegal branch", {25'h0, 7'b1100011}, 64'd7, 64'd9, act);

		// second issue before any read, result keeps the later one
		wb_write(adr_src1, 64'd100);
		wb_write(adr_src2, 64'd30);
		wb_write(adr_instr, {32'b0, enc_r(f7_base, f3_add, op_op)});
		ins = enc_r(f7_alt, f3_add, op_op);
		wb_write(adr_instr, {32'b0, ins});
		wb_read(adr_result, act);
		wb_read(adr_status, st);
		rv_ref(ins, 64'd100, 64'd30, exp, ill);
		post("back to back add then sub", exp, act, {{(xlen-2){1'b0}}, ill, 1'b1}, st);

		for (i = 0; i < n_random; i++) begin
			s1  = {$random(seed), $random(seed)};
			s2  = {$random(seed), $random(seed)};
			ins = rand_instr();
			run_test($sformatf("random %0d instr %h", i, ins), ins, s1, s2, act);
		end

		@(negedge clk);  // compare process drains
		$display("tests run %0d of %0d, failures %0d", n_run, n_tests, n_fail);
		if (n_fail == 0 && n_run == n_tests)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule
